// File: rtl/timer_pkg.sv
package timer_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // time value
  ////////////////////////////////////////////////////////////////////////////

  // bcd mm:ss, fields ordered so a plain compare follows time order
  typedef struct packed {
    logic [2:0] min_tens;
    logic [3:0] min_ones;
    logic [2:0] sec_tens;
    logic [3:0] sec_ones;
  } mmss_t;

  // lower limit 10:20
  localparam mmss_t MIN_TIME = '{min_tens: 3'd1, min_ones: 4'd0,
                                 sec_tens: 3'd2, sec_ones: 4'd0};

  // upper limit 49:30
  localparam mmss_t MAX_TIME = '{min_tens: 3'd4, min_ones: 4'd9,
                                 sec_tens: 3'd3, sec_ones: 4'd0};

  // minutes added or taken per jump
  localparam integer JUMP_MINUTES = 2;

  ////////////////////////////////////////////////////////////////////////////
  // display word
  ////////////////////////////////////////////////////////////////////////////

  // four nibbles, reads as hex MMSS
  typedef logic [15:0] display_t;

  // shown in flash mode while blink is high
  localparam display_t FLASH_PATTERN = 16'h5555;

endpackage

// File: rtl/ctrl_pkg.sv
package ctrl_pkg;

  // one-cycle commands into the counter
  typedef enum logic [1:0] {
    OP_IDLE  = 2'd0,
    OP_JUMP  = 2'd1,
    OP_CLEAR = 2'd2
  } op_e;

  // tick rate selection
  typedef enum logic [1:0] {
    SPEED_NORMAL = 2'd0,
    SPEED_HALF   = 2'd1,
    SPEED_DOUBLE = 2'd2
  } speed_e;

endpackage

// File: rtl/timer_cmd_if.sv
interface timer_cmd_if;

  ctrl_pkg::op_e    op;
  logic             count_up;
  logic             run;
  ctrl_pkg::speed_e speed;
  logic             flash;

  modport decode (
    output op,
    output count_up,
    output run,
    output speed,
    output flash
  );

  modport execute (
    input op,
    input count_up,
    input run,
    input speed
  );

  modport result (
    input flash
  );

endinterface

// File: rtl/button_decode.sv
module button_decode (
  input  logic         clk,
  input  logic         reset,
  input  logic         enable,
  input  logic         count_down,
  input  logic         add_two,
  input  logic         half_speed,
  input  logic         double_speed,
  input  logic         clear,
  timer_cmd_if.decode  cmd
);

  logic add_two_q;
  logic both_speed;
  logic jump_edge;

  assign both_speed = half_speed & double_speed;

  // one jump per press, however long it is held
  assign jump_edge = add_two & ~add_two_q;

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      add_two_q    <= 1'b0;
      cmd.op       <= ctrl_pkg::OP_IDLE;
      cmd.count_up <= 1'b1;
      cmd.run      <= 1'b0;
      cmd.speed    <= ctrl_pkg::SPEED_NORMAL;
      cmd.flash    <= 1'b0;
    end
    else
    begin
      add_two_q <= add_two;

      if (clear)
        cmd.op <= ctrl_pkg::OP_CLEAR;
      else if (jump_edge)
        cmd.op <= ctrl_pkg::OP_JUMP;
      else
        cmd.op <= ctrl_pkg::OP_IDLE;

      // direction only latched while paused
      if (!enable)
        cmd.count_up <= ~count_down;

      cmd.flash <= both_speed;
      cmd.run   <= enable & ~both_speed;

      case ({half_speed, double_speed})
        2'b10:   cmd.speed <= ctrl_pkg::SPEED_HALF;
        2'b01:   cmd.speed <= ctrl_pkg::SPEED_DOUBLE;
        default: cmd.speed <= ctrl_pkg::SPEED_NORMAL;
      endcase
    end
  end

endmodule

// File: rtl/tick_divider.sv
module tick_divider #(
  parameter int TICK_CYCLES = 50000000
) (
  input  logic             clk,
  input  logic             reset,
  input  ctrl_pkg::speed_e speed,
  output logic             tick,
  output logic             blink
);

  localparam int CNT_W = $clog2(2 * TICK_CYCLES);

  localparam logic [CNT_W-1:0] TERM_NORMAL = CNT_W'(TICK_CYCLES - 1);
  localparam logic [CNT_W-1:0] TERM_HALF   = CNT_W'(2 * TICK_CYCLES - 1);
  localparam logic [CNT_W-1:0] TERM_DOUBLE = CNT_W'(TICK_CYCLES / 2 - 1);

  logic [CNT_W-1:0] count;
  logic [CNT_W-1:0] term;
  ctrl_pkg::speed_e speed_q;
  logic             speed_change;

  always_comb
  begin
    case (speed)
      ctrl_pkg::SPEED_HALF:   term = TERM_HALF;
      ctrl_pkg::SPEED_DOUBLE: term = TERM_DOUBLE;
      default:                term = TERM_NORMAL;
    endcase
  end

  assign speed_change = (speed != speed_q);

  // no tick in the cycle the rate switches
  assign tick = (count == term) && !speed_change;

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      count   <= '0;
      speed_q <= ctrl_pkg::SPEED_NORMAL;
      blink   <= 1'b0;
    end
    else
    begin
      speed_q <= speed;
      if (speed_change || tick)
        count <= '0;
      else
        count <= count + 1'b1;
      if (tick)
        blink <= ~blink;
    end
  end

endmodule

// File: rtl/mmss_counter.sv
module mmss_counter #(
  parameter int TICK_CYCLES = 50000000
) (
  input  logic              clk,
  input  logic              reset,
  timer_cmd_if.execute      cmd,
  output timer_pkg::mmss_t  time_val,
  output logic              blink
);

  logic tick;
  logic at_limit;

  ////////////////////////////////////////////////////////////////////////////
  // bcd arithmetic
  ////////////////////////////////////////////////////////////////////////////

  // one second up or down with carry and borrow across the digits
  function automatic timer_pkg::mmss_t step_second(input timer_pkg::mmss_t t,
                                                   input logic up);
    timer_pkg::mmss_t r;
    r = t;
    if (up)
    begin
      if (t.sec_ones != 4'd9)
        r.sec_ones = t.sec_ones + 4'd1;
      else
      begin
        r.sec_ones = 4'd0;
        if (t.sec_tens != 3'd5)
          r.sec_tens = t.sec_tens + 3'd1;
        else
        begin
          r.sec_tens = 3'd0;
          if (t.min_ones != 4'd9)
            r.min_ones = t.min_ones + 4'd1;
          else
          begin
            r.min_ones = 4'd0;
            r.min_tens = t.min_tens + 3'd1;
          end
        end
      end
    end
    else
    begin
      if (t.sec_ones != 4'd0)
        r.sec_ones = t.sec_ones - 4'd1;
      else
      begin
        r.sec_ones = 4'd9;
        if (t.sec_tens != 3'd0)
          r.sec_tens = t.sec_tens - 3'd1;
        else
        begin
          r.sec_tens = 3'd5;
          if (t.min_ones != 4'd0)
            r.min_ones = t.min_ones - 4'd1;
          else
          begin
            r.min_ones = 4'd9;
            r.min_tens = t.min_tens - 3'd1;
          end
        end
      end
    end
    return r;
  endfunction

  // minute jump, clamped to the limits
  function automatic timer_pkg::mmss_t jump_minutes(input timer_pkg::mmss_t t,
                                                    input logic up);
    logic [6:0]       mins;
    timer_pkg::mmss_t r;
    mins = 7'(t.min_tens) * 7'd10 + 7'(t.min_ones);
    r    = t;
    if (up)
      mins = mins + 7'(timer_pkg::JUMP_MINUTES);
    else if (mins >= 7'(timer_pkg::JUMP_MINUTES))
      mins = mins - 7'(timer_pkg::JUMP_MINUTES);
    else
      mins = 7'd0;
    r.min_tens = 3'(mins / 7'd10);
    r.min_ones = 4'(mins % 7'd10);
    if (r > timer_pkg::MAX_TIME)
      r = timer_pkg::MAX_TIME;
    else if (r < timer_pkg::MIN_TIME)
      r = timer_pkg::MIN_TIME;
    return r;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // time register
  ////////////////////////////////////////////////////////////////////////////

  tick_divider #(
    .TICK_CYCLES (TICK_CYCLES)
  ) i_tick_divider (
    .clk   (clk),
    .reset (reset),
    .speed (cmd.speed),
    .tick  (tick),
    .blink (blink)
  );

  // stop once the limit in the counting direction is reached
  assign at_limit = cmd.count_up ? (time_val == timer_pkg::MAX_TIME)
                                 : (time_val == timer_pkg::MIN_TIME);

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      time_val <= timer_pkg::MIN_TIME;
    else
    begin
      case (cmd.op)
        ctrl_pkg::OP_CLEAR:
          time_val <= cmd.count_up ? timer_pkg::MIN_TIME : timer_pkg::MAX_TIME;
        ctrl_pkg::OP_JUMP:
          time_val <= jump_minutes(time_val, cmd.count_up);
        default:
        begin
          if (tick && cmd.run && !at_limit)
            time_val <= step_second(time_val, cmd.count_up);
        end
      endcase
    end
  end

endmodule

// File: rtl/display_format.sv
module display_format (
  input  timer_pkg::mmss_t     time_val,
  input  logic                 blink,
  timer_cmd_if.result          cmd,
  output timer_pkg::display_t  display
);

  timer_pkg::display_t digits;

  // zero spacer above each tens digit
  assign digits = {1'b0, time_val.min_tens,
                   time_val.min_ones,
                   1'b0, time_val.sec_tens,
                   time_val.sec_ones};

  always_comb
  begin
    if (cmd.flash)
    begin
      if (blink)
        display = timer_pkg::FLASH_PATTERN;
      else
        display = '0;
    end
    else
    begin
      display = digits;
    end
  end

endmodule

// File: rtl/mmss_timer.sv
module mmss_timer #(
  parameter int TICK_CYCLES = 50000000
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 enable,
  input  logic                 count_down,
  input  logic                 add_two,
  input  logic                 half_speed,
  input  logic                 double_speed,
  input  logic                 clear,
  output timer_pkg::display_t  display,
  output logic                 blink
);

  timer_pkg::mmss_t time_val;

  timer_cmd_if cmd ();

  // decode
  button_decode i_button_decode (
    .clk          (clk),
    .reset        (reset),
    .enable       (enable),
    .count_down   (count_down),
    .add_two      (add_two),
    .half_speed   (half_speed),
    .double_speed (double_speed),
    .clear        (clear),
    .cmd          (cmd.decode)
  );

  // execute
  mmss_counter #(
    .TICK_CYCLES (TICK_CYCLES)
  ) i_mmss_counter (
    .clk      (clk),
    .reset    (reset),
    .cmd      (cmd.execute),
    .time_val (time_val),
    .blink    (blink)
  );

  // result
  display_format i_display_format (
    .time_val (time_val),
    .blink    (blink),
    .cmd      (cmd.result),
    .display  (display)
  );

endmodule

// File: testbench/mmss_timer_assertions.sv
module mmss_timer_assertions (
  input logic             clk,
  input logic             reset,
  input timer_pkg::mmss_t time_val,
  input ctrl_pkg::op_e    op
);

  // every digit a legal bcd value
  bcd_digits: assert property (@(posedge clk) disable iff (reset)
    time_val.sec_ones <= 4'd9 && time_val.sec_tens <= 3'd5 &&
    time_val.min_ones <= 4'd9 && time_val.min_tens <= 3'd5)
    else $error("time %h has a digit outside the bcd range", time_val);

  within_limits: assert property (@(posedge clk) disable iff (reset)
    time_val >= timer_pkg::MIN_TIME && time_val <= timer_pkg::MAX_TIME)
    else $error("time %h is outside the limits", time_val);

  // a held button gives a single jump
  single_jump: assert property (@(posedge clk) disable iff (reset)
    op == ctrl_pkg::OP_JUMP |=> op != ctrl_pkg::OP_JUMP)
    else $error("jump opcode held for two cycles");

endmodule

bind mmss_counter mmss_timer_assertions i_mmss_timer_assertions (
  .clk      (clk),
  .reset    (reset),
  .time_val (time_val),
  .op       (cmd.op)
);

// File: testbench/tb_mmss_timer.sv
module tb_mmss_timer;

  localparam int TICK_CYCLES = 8;
  // longest gap between display changes at half speed plus pipeline
  localparam int WAIT_LIMIT = 2 * TICK_CYCLES + 8;
  localparam int RUN_STEPS = 300;
  localparam int PRESSES = 90;
  localparam int TIMEOUT_CYCLES = 10 + RUN_STEPS * (TICK_CYCLES + 4) + PRESSES * 8
                                  + 40 * TICK_CYCLES + 500;

  logic                clk;
  logic                reset;
  logic                enable;
  logic                count_down;
  logic                add_two;
  logic                half_speed;
  logic                double_speed;
  logic                clear;
  timer_pkg::display_t display;
  logic                blink;

  int               errors;
  int               checks;
  int               tests;
  int               cycle_count;
  timer_pkg::mmss_t model;
  logic             model_up;

  mmss_timer #(
    .TICK_CYCLES (TICK_CYCLES)
  ) i_mmss_timer (
    .clk          (clk),
    .reset        (reset),
    .enable       (enable),
    .count_down   (count_down),
    .add_two      (add_two),
    .half_speed   (half_speed),
    .double_speed (double_speed),
    .clear        (clear),
    .display      (display),
    .blink        (blink)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial
  begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES)
    begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Errors found");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // reference model kept in plain seconds
  ////////////////////////////////////////////////////////////////////////////

  function automatic int to_secs(input timer_pkg::mmss_t t);
    return (int'(t.min_tens) * 10 + int'(t.min_ones)) * 60
           + int'(t.sec_tens) * 10 + int'(t.sec_ones);
  endfunction

  function automatic timer_pkg::mmss_t from_secs(input int s);
    timer_pkg::mmss_t r;
    r.min_tens = 3'((s / 60) / 10);
    r.min_ones = 4'((s / 60) % 10);
    r.sec_tens = 3'((s % 60) / 10);
    r.sec_ones = 4'((s % 60) % 10);
    return r;
  endfunction

  function automatic timer_pkg::display_t expected_display(input timer_pkg::mmss_t t);
    int m;
    int s;
    m = to_secs(t) / 60;
    s = to_secs(t) % 60;
    return {4'(m / 10), 4'(m % 10), 4'(s / 10), 4'(s % 10)};
  endfunction

  // one second or one jump clamped to the limits
  task automatic model_update(inout timer_pkg::mmss_t t, input logic up, input logic jump);
    int s;
    int amount;
    amount = jump ? timer_pkg::JUMP_MINUTES * 60 : 1;
    s = up ? to_secs(t) + amount : to_secs(t) - amount;
    if (s > to_secs(timer_pkg::MAX_TIME))
      s = to_secs(timer_pkg::MAX_TIME);
    if (s < to_secs(timer_pkg::MIN_TIME))
      s = to_secs(timer_pkg::MIN_TIME);
    t = from_secs(s);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // checks and helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_display(input string name, input timer_pkg::display_t got,
                               input timer_pkg::display_t exp);
    checks++;
    if (got !== exp)
    begin
      $display("Mismatch at %0t: %s = %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp)
    begin
      $display("Mismatch at %0t: %s = %b, expected %b", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_count(input string name, input int got, input int lo, input int hi);
    checks++;
    if (got < lo || got > hi)
    begin
      $display("Mismatch at %0t: %s = %0d, expected %0d to %0d", $time, name, got, lo, hi);
      errors++;
    end
  endtask

  task automatic wait_change();
    timer_pkg::display_t prev;
    int n;
    prev = display;
    n = 0;
    while (display == prev && n < WAIT_LIMIT)
    begin
      @(negedge clk);
      n++;
    end
    if (display == prev)
    begin
      $display("At %0t the display did not change within %0d cycles", $time, WAIT_LIMIT);
      errors++;
    end
  endtask

  task automatic step_and_check();
    wait_change();
    model_update(model, model_up, 1'b0);
    check_display("display", display, expected_display(model));
  endtask

  // every change seen is one model step and one blink toggle
  task automatic count_changes(input int cycles, output int n);
    timer_pkg::display_t prev;
    logic                last_blink;
    prev = display;
    last_blink = 1'b0;
    n = 0;
    repeat (cycles)
    begin
      @(negedge clk);
      if (display != prev)
      begin
        model_update(model, model_up, 1'b0);
        check_display("display", display, expected_display(model));
        if (n > 0)
          check_bit("blink", blink, ~last_blink);
        last_blink = blink;
        prev = display;
        n++;
      end
    end
  endtask

  task automatic press_jump(input int hold);
    add_two = 1'b1;
    repeat (hold) @(negedge clk);
    add_two = 1'b0;
    repeat (2) @(negedge clk);
    model_update(model, model_up, 1'b1);
    check_display("display after jump", display, expected_display(model));
  endtask

  // only while paused
  task automatic set_direction(input logic down);
    count_down = down;
    repeat (2) @(negedge clk);
    model_up = ~down;
  endtask

  task automatic pulse_clear();
    clear = 1'b1;
    @(negedge clk);
    clear = 1'b0;
    repeat (2) @(negedge clk);
    model = model_up ? timer_pkg::MIN_TIME : timer_pkg::MAX_TIME;
  endtask

  task automatic pause();
    enable = 1'b0;
    repeat (2) @(negedge clk);
  endtask

  task automatic finish_test(input string name, input int start);
    tests++;
    $display("%s: %0d errors", name, errors - start);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic test_reset();
    int start;
    start = errors;
    model = timer_pkg::MIN_TIME;
    model_up = 1'b1;
    check_display("display", display, 16'h1020);
    check_bit("blink", blink, 1'b0);
    finish_test("reset", start);
  endtask

  task automatic test_count_up();
    int start;
    int n;
    start = errors;
    enable = 1'b1;
    // 10:20 through the 10:59 rollover to 11:05
    repeat (45) step_and_check();
    pause();
    count_changes(4 * TICK_CYCLES, n);
    check_count("changes while paused", n, 0, 0);
    finish_test("count up", start);
  endtask

  task automatic test_direction();
    int start;
    start = errors;
    enable = 1'b1;
    step_and_check();
    // ignored while running
    count_down = 1'b1;
    repeat (3) step_and_check();
    pause();
    model_up = 1'b0;
    enable = 1'b1;
    repeat (5) step_and_check();
    pause();
    finish_test("direction", start);
  endtask

  task automatic test_jump();
    int start;
    start = errors;
    set_direction(1'b0);
    press_jump(20);
    while (model != timer_pkg::MAX_TIME)
      press_jump(3);
    check_display("display at upper limit", display, 16'h4930);
    set_direction(1'b1);
    while (model != timer_pkg::MIN_TIME)
      press_jump(3);
    check_display("display at lower limit", display, 16'h1020);
    finish_test("jump", start);
  endtask

  task automatic test_limits_clear();
    int start;
    int n;
    start = errors;
    set_direction(1'b0);
    // 10:20 up to 48:20 then count into the limit
    repeat (19) press_jump(3);
    enable = 1'b1;
    repeat (70) step_and_check();
    check_display("display at upper limit", display, 16'h4930);
    count_changes(4 * TICK_CYCLES, n);
    check_count("changes at upper limit", n, 0, 0);
    pause();
    pulse_clear();
    check_display("display after clear up", display, 16'h1020);
    set_direction(1'b1);
    pulse_clear();
    check_display("display after clear down", display, 16'h4930);
    repeat (19) press_jump(3);
    enable = 1'b1;
    repeat (70) step_and_check();
    check_display("display at lower limit", display, 16'h1020);
    count_changes(4 * TICK_CYCLES, n);
    check_count("changes at lower limit", n, 0, 0);
    pause();
    finish_test("limits and clear", start);
  endtask

  task automatic test_speed_flash();
    int   start;
    int   n;
    logic seen_high;
    logic seen_low;
    start = errors;
    seen_high = 1'b0;
    seen_low = 1'b0;
    set_direction(1'b0);
    enable = 1'b1;
    count_changes(2 * TICK_CYCLES, n);
    count_changes(16 * TICK_CYCLES, n);
    check_count("changes at normal speed", n, 15, 17);
    double_speed = 1'b1;
    count_changes(2 * TICK_CYCLES, n);
    count_changes(16 * TICK_CYCLES, n);
    check_count("changes at double speed", n, 31, 33);
    half_speed = 1'b1;
    double_speed = 1'b0;
    count_changes(4 * TICK_CYCLES, n);
    count_changes(16 * TICK_CYCLES, n);
    check_count("changes at half speed", n, 7, 9);
    // enter flash just after a step
    step_and_check();
    double_speed = 1'b1;
    repeat (2) @(negedge clk);
    repeat (8 * TICK_CYCLES)
    begin
      @(negedge clk);
      check_display("display in flash", display,
                    blink ? timer_pkg::FLASH_PATTERN : 16'h0000);
      if (blink)
        seen_high = 1'b1;
      else
        seen_low = 1'b1;
    end
    check_bit("blink high during flash", seen_high, 1'b1);
    check_bit("blink low during flash", seen_low, 1'b1);
    enable = 1'b0;
    half_speed = 1'b0;
    double_speed = 1'b0;
    repeat (2) @(negedge clk);
    check_display("display after flash", display, expected_display(model));
    finish_test("speed and flash", start);
  endtask

  initial
  begin
    reset = 1'b1;
    enable = 1'b0;
    count_down = 1'b0;
    add_two = 1'b0;
    half_speed = 1'b0;
    double_speed = 1'b0;
    clear = 1'b0;
    errors = 0;
    checks = 0;
    tests = 0;
    repeat (10) @(negedge clk);
    reset = 1'b0;
    test_reset();
    test_count_up();
    test_direction();
    test_jump();
    test_limits_clear();
    test_speed_flash();
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

endmodule

// File: files.f
rtl/timer_pkg.sv
rtl/ctrl_pkg.sv
rtl/timer_cmd_if.sv
rtl/button_decode.sv
rtl/tick_divider.sv
rtl/mmss_counter.sv
rtl/display_format.sv
rtl/mmss_timer.sv
testbench/mmss_timer_assertions.sv
testbench/tb_mmss_timer.sv

// File: run.sh
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_mmss_timer -f files.f -o tb_mmss_timer
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

output=$(./obj_dir/tb_mmss_timer 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "No errors" <<< "$output"; then
  exit 0
fi
exit 1
